/* hw/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    // datapath and register file geometry
    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // per-register issue/writeback counters
    // 2 bits leave room for the wrap between front and rear
    localparam int REG_STATUS_WIDTH = 2;

    // exit reporting and retired counter
    localparam int EXIT_CODE_WIDTH = 8;
    localparam int RETIRED_WIDTH = 32;
    localparam logic [EXIT_CODE_WIDTH-1:0] EXIT_CODE_ILLEGAL = 8'd1;

    // a0 holds the exit argument for ebreak
    localparam logic [REG_ADDR_WIDTH-1:0] EXIT_ARG_REG = 5'd10;

    // funct12 of ebreak in the system opcode space
    localparam logic [11:0] FUNCT12_EBREAK = 12'h001;

    // funct3 encodings of the integer alu
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL = 3'b001;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

    // funct3 of ecall/ebreak
    localparam logic [2:0] FUNCT3_PRIV = 3'b000;

    // funct7 values, alt selects sub and sra
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // major opcodes kept by this stage
    typedef enum logic [6:0] {
        OPCODE_OP = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI = 7'b0110111,
        OPCODE_AUIPC = 7'b0010111,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_SLL = 4'd2,
        ALU_SLT = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7,
        ALU_OR = 4'd8,
        ALU_AND = 4'd9
    } alu_op_t;

    // source of execute operand a
    typedef enum logic [1:0] {
        A_SEL_RS1 = 2'd0,
        A_SEL_ZERO = 2'd1,
        A_SEL_PC = 2'd2
    } operand_a_sel_t;

    typedef enum logic [1:0] {
        STAGE_RESET = 2'd0,
        STAGE_NORMAL = 2'd1,
        STAGE_EXIT = 2'd2
    } stage_state_t;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import decode_pkg::*;
(
    input wire [XLEN-1:0] instr_data,

    output logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [REG_ADDR_WIDTH-1:0] rd_addr,
    output alu_op_t alu_op,
    output operand_a_sel_t a_sel,
    output logic use_imm,
    output logic [XLEN-1:0] imm,
    output logic writes_rd,
    output logic is_ebreak,
    output logic illegal
);

    // funct3 to alu operation, alt bit only matters for add/sub and shifts
    function automatic alu_op_t alu_from_funct3(
            input logic [2:0] funct3,
            input logic alt,
            input logic reg_reg
    );
        case (funct3)
            FUNCT3_ADD_SUB: return (alt && reg_reg) ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL: return ALU_SLL;
            FUNCT3_SLT: return ALU_SLT;
            FUNCT3_SLTU: return ALU_SLTU;
            FUNCT3_XOR: return ALU_XOR;
            FUNCT3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [REG_ADDR_WIDTH-1:0] rd_field, rs1_field, rs2_field;
    logic [XLEN-1:0] imm_i, imm_u;
    logic funct7_ok_reg, funct7_ok_imm;

    // raw instruction fields
    assign opcode = opcode_t'(instr_data[6:0]);
    assign rd_field = instr_data[11:7];
    assign funct3 = instr_data[14:12];
    assign rs1_field = instr_data[19:15];
    assign rs2_field = instr_data[24:20];
    assign funct7 = instr_data[31:25];

    // sign extended i-type, upper u-type
    assign imm_i = {{20{instr_data[31]}}, instr_data[31:20]};
    assign imm_u = {instr_data[31:12], 12'b0};

    // alt funct7 only legal on add/sub and srl/sra
    assign funct7_ok_reg = (funct7 == FUNCT7_BASE) ||
            (funct7 == FUNCT7_ALT &&
            (funct3 == FUNCT3_ADD_SUB || funct3 == FUNCT3_SRL_SRA));
    // immediate shifts reuse funct7, everything else is plain immediate
    assign funct7_ok_imm = (funct3 == FUNCT3_SLL) ? (funct7 == FUNCT7_BASE) :
            (funct3 == FUNCT3_SRL_SRA) ? (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT) :
            1'b1;

    always_comb begin
        // defaults describe a nop that reads nothing
        rs1_addr = '0;
        rs2_addr = '0;
        rd_addr = '0;
        alu_op = ALU_ADD;
        a_sel = A_SEL_ZERO;
        use_imm = 1'b1;
        imm = imm_i;
        writes_rd = 1'b0;
        is_ebreak = 1'b0;
        illegal = 1'b0;

        case (opcode)
            OPCODE_OP: begin
                if (funct7_ok_reg) begin
                    rs1_addr = rs1_field;
                    rs2_addr = rs2_field;
                    a_sel = A_SEL_RS1;
                    use_imm = 1'b0;
                    alu_op = alu_from_funct3(funct3, funct7[5], 1'b1);
                    writes_rd = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            OPCODE_OP_IMM: begin
                if (funct7_ok_imm) begin
                    rs1_addr = rs1_field;
                    a_sel = A_SEL_RS1;
                    alu_op = alu_from_funct3(funct3, funct7[5], 1'b0);
                    writes_rd = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            OPCODE_LUI: begin
                // zero plus upper immediate
                imm = imm_u;
                writes_rd = 1'b1;
            end
            OPCODE_AUIPC: begin
                a_sel = A_SEL_PC;
                imm = imm_u;
                writes_rd = 1'b1;
            end
            OPCODE_SYSTEM: begin
                // only ebreak survives, its exit argument comes from a0
                if (instr_data[31:20] == FUNCT12_EBREAK && funct3 == FUNCT3_PRIV &&
                        rs1_field == '0 && rd_field == '0) begin
                    is_ebreak = 1'b1;
                    rs1_addr = EXIT_ARG_REG;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // destination only named when something is written
        if (writes_rd) begin
            rd_addr = rd_field;
        end
    end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import decode_pkg::*;
(
    input wire clk,
    input wire reset,

    // sequential clear after reset
    input wire clear_en,
    input wire [REG_ADDR_WIDTH-1:0] clear_addr,

    // writebacks from execute
    input wire wb_valid,
    input wire [REG_ADDR_WIDTH-1:0] wb_addr,
    input wire [XLEN-1:0] wb_value,

    // two combinational read ports
    input wire [REG_ADDR_WIDTH-1:0] rs1_addr,
    input wire [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [XLEN-1:0] rs1_value,
    output logic [XLEN-1:0] rs2_value
);

    logic [XLEN-1:0] regs [REG_COUNT];

    // one write port, shared between clearing and writeback
    always_ff @(posedge clk) begin
        if (clear_en) begin
            regs[clear_addr] <= '0;
        end else if (wb_valid) begin
            regs[wb_addr] <= wb_value;
        end
    end

    // x0 is hardwired
    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // nothing is in flight while the stage is still clearing,
    // so execute has no business writing back yet
    property no_writeback_while_clearing;
        @(posedge clk) disable iff (reset)
        clear_en |-> !wb_valid;
    endproperty

    assert property (no_writeback_while_clearing)
        else $error("writeback to x%0d during register clear", wb_addr);

endmodule

`default_nettype wire

/* hw/reg_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_scoreboard
    import decode_pkg::*;
(
    input wire clk,
    input wire reset,

    // counter clearing after reset
    input wire clear_en,
    input wire [REG_ADDR_WIDTH-1:0] clear_addr,

    // issue side
    input wire issue_en,
    input wire [REG_ADDR_WIDTH-1:0] rd_addr,
    input wire [REG_ADDR_WIDTH-1:0] rs1_addr,
    input wire [REG_ADDR_WIDTH-1:0] rs2_addr,

    // writeback side
    input wire wb_valid,
    input wire [REG_ADDR_WIDTH-1:0] wb_addr,

    output logic hazard
);

    // front counts issued writers, rear counts returned writebacks
    logic [REG_STATUS_WIDTH-1:0] front_status [REG_COUNT];
    logic [REG_STATUS_WIDTH-1:0] rear_status [REG_COUNT];

    logic rs1_pending, rs2_pending, rd_pending, wb_pending;

    // front advances only for a real destination
    always_ff @(posedge clk) begin
        if (clear_en) begin
            front_status[clear_addr] <= '0;
        end else if (issue_en && rd_addr != '0) begin
            front_status[rd_addr] <= front_status[rd_addr] + REG_STATUS_WIDTH'(1);
        end
    end

    // rear advances on every writeback
    always_ff @(posedge clk) begin
        if (clear_en) begin
            rear_status[clear_addr] <= '0;
        end else if (wb_valid) begin
            rear_status[wb_addr] <= rear_status[wb_addr] + REG_STATUS_WIDTH'(1);
        end
    end

    // outstanding write whenever the counters disagree
    assign rs1_pending = front_status[rs1_addr] != rear_status[rs1_addr];
    assign rs2_pending = front_status[rs2_addr] != rear_status[rs2_addr];
    assign rd_pending = front_status[rd_addr] != rear_status[rd_addr];
    assign wb_pending = front_status[wb_addr] != rear_status[wb_addr];

    // raw on either source, waw on the destination
    assign hazard = rs1_pending || rs2_pending || rd_pending;

    // every writeback must match a command issued earlier from here
    property writeback_was_issued;
        @(posedge clk) disable iff (reset)
        wb_valid |-> wb_pending;
    endproperty

    assert property (writeback_was_issued)
        else $error("writeback to x%0d with no write outstanding", wb_addr);

endmodule

`default_nettype wire

/* hw/issue_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_controller
    import decode_pkg::*;
(
    input wire clk,
    input wire reset,

    // instruction input
    input wire instr_valid,
    input wire [XLEN-1:0] instr_pc,
    output logic instr_ready,

    // decoded fields
    input wire [REG_ADDR_WIDTH-1:0] rd_addr,
    input var alu_op_t alu_op,
    input var operand_a_sel_t a_sel,
    input wire use_imm,
    input wire [XLEN-1:0] imm,
    input wire writes_rd,
    input wire is_ebreak,
    input wire illegal,

    // register file and scoreboard
    input wire [XLEN-1:0] rs1_value,
    input wire [XLEN-1:0] rs2_value,
    input wire hazard,
    output logic issue_en,
    output logic clear_en,
    output logic [REG_ADDR_WIDTH-1:0] clear_addr,

    // execute command
    output logic exec_valid,
    input wire exec_ready,
    output alu_op_t exec_op,
    output logic [XLEN-1:0] exec_a,
    output logic [XLEN-1:0] exec_b,
    output logic [REG_ADDR_WIDTH-1:0] exec_rd,
    output logic exec_halt,

    // status
    output logic exit_flag,
    output logic [EXIT_CODE_WIDTH-1:0] exit_code,
    output logic [RETIRED_WIDTH-1:0] retired_count
);

    stage_state_t state, next_state;
    logic [REG_ADDR_WIDTH-1:0] clear_counter;
    logic out_free, accept, halting;
    logic [XLEN-1:0] operand_a;

    // output register empty or draining this cycle
    assign out_free = !exec_valid || exec_ready;
    assign halting = is_ebreak || illegal;

    // clearing walks every register while in reset state
    assign clear_en = (state == STAGE_RESET);
    assign clear_addr = clear_counter;
    assign exit_flag = (state == STAGE_EXIT);

    // scoreboard only tracks real writers
    assign issue_en = accept && writes_rd;

    always_comb begin
        next_state = state;
        instr_ready = 1'b0;
        accept = 1'b0;
        case (state)
            STAGE_RESET: begin
                if (clear_counter == REG_ADDR_WIDTH'(REG_COUNT - 1)) begin
                    next_state = STAGE_NORMAL;
                end
            end
            STAGE_NORMAL: begin
                instr_ready = out_free && !hazard;
                accept = instr_valid && instr_ready;
                if (accept && halting) begin
                    next_state = STAGE_EXIT;
                end
            end
            STAGE_EXIT: begin
                // swallow everything after the halt
                instr_ready = 1'b1;
            end
            default: begin
                next_state = STAGE_RESET;
            end
        endcase
    end

    // operand a source
    always_comb begin
        case (a_sel)
            A_SEL_RS1: operand_a = rs1_value;
            A_SEL_PC: operand_a = instr_pc;
            default: operand_a = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= STAGE_RESET;
            clear_counter <= '0;
            exec_valid <= 1'b0;
            exit_code <= '0;
            retired_count <= '0;
        end else begin
            state <= next_state;
            if (clear_en) begin
                clear_counter <= clear_counter + REG_ADDR_WIDTH'(1);
            end
            // load wins over drain, one slot only
            if (accept) begin
                exec_valid <= 1'b1;
            end else if (exec_ready) begin
                exec_valid <= 1'b0;
            end
            // ebreak reports low byte of a0
            if (accept && halting) begin
                exit_code <= illegal ? EXIT_CODE_ILLEGAL : rs1_value[EXIT_CODE_WIDTH-1:0];
            end
            if (accept && !halting) begin
                retired_count <= retired_count + RETIRED_WIDTH'(1);
            end
        end
    end

    // command payload, qualified by exec_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            exec_op <= alu_op;
            exec_a <= operand_a;
            exec_b <= use_imm ? imm : rs2_value;
            exec_rd <= rd_addr;
            exec_halt <= halting;
        end
    end

    // a stalled command must reach execute unchanged
    property command_held;
        @(posedge clk) disable iff (reset)
        exec_valid && !exec_ready |=> exec_valid && $stable(exec_op) && $stable(exec_a) &&
                $stable(exec_b) && $stable(exec_rd) && $stable(exec_halt);
    endproperty

    assert property (command_held)
        else $error("execute command changed under back-pressure");

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input wire clk,
    input wire reset,

    // instruction stream
    input wire instr_valid,
    output wire instr_ready,
    input wire [XLEN-1:0] instr_data,
    input wire [XLEN-1:0] instr_pc,

    // execute stream
    output wire exec_valid,
    input wire exec_ready,
    output alu_op_t exec_op,
    output wire [XLEN-1:0] exec_a,
    output wire [XLEN-1:0] exec_b,
    output wire [REG_ADDR_WIDTH-1:0] exec_rd,
    output wire exec_halt,

    // writebacks, no flow control
    input wire wb_valid,
    input wire [REG_ADDR_WIDTH-1:0] wb_addr,
    input wire [XLEN-1:0] wb_value,

    // status
    output wire exit_flag,
    output wire [EXIT_CODE_WIDTH-1:0] exit_code,
    output wire [RETIRED_WIDTH-1:0] retired_count
);

    // decoder outputs
    logic [REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr, rd_addr;
    alu_op_t alu_op;
    operand_a_sel_t a_sel;
    logic use_imm, writes_rd, is_ebreak, illegal;
    logic [XLEN-1:0] imm;

    // register file, scoreboard, control
    logic [XLEN-1:0] rs1_value, rs2_value;
    logic hazard, issue_en, clear_en;
    logic [REG_ADDR_WIDTH-1:0] clear_addr;

    instr_decoder instr_decoder_inst (
        .instr_data,
        .rs1_addr, .rs2_addr, .rd_addr,
        .alu_op, .a_sel, .use_imm, .imm,
        .writes_rd, .is_ebreak, .illegal
    );

    register_file register_file_inst (
        .clk, .reset,
        .clear_en, .clear_addr,
        .wb_valid, .wb_addr, .wb_value,
        .rs1_addr, .rs2_addr,
        .rs1_value, .rs2_value
    );

    reg_scoreboard reg_scoreboard_inst (
        .clk, .reset,
        .clear_en, .clear_addr,
        .issue_en, .rd_addr, .rs1_addr, .rs2_addr,
        .wb_valid, .wb_addr,
        .hazard
    );

    issue_controller issue_controller_inst (
        .clk, .reset,
        .instr_valid, .instr_pc, .instr_ready,
        .rd_addr, .alu_op, .a_sel, .use_imm, .imm,
        .writes_rd, .is_ebreak, .illegal,
        .rs1_value, .rs2_value, .hazard,
        .issue_en, .clear_en, .clear_addr,
        .exec_valid, .exec_ready, .exec_op, .exec_a, .exec_b, .exec_rd, .exec_halt,
        .exit_flag, .exit_code, .retired_count
    );

endmodule

`default_nettype wire

/* verification/tb_decode_model.svh */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// architectural registers as seen in program order
logic [31:0] model_regs [32];

// reference alu for the expected results and the writeback values
function automatic logic [31:0] model_alu(input alu_op_t op, input logic [31:0] a,
        input logic [31:0] b);
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_SLL: return a << b[4:0];
        ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
        ALU_SLTU: return {31'b0, a < b};
        ALU_XOR: return a ^ b;
        ALU_SRL: return a >> b[4:0];
        ALU_SRA: return $signed(a) >>> b[4:0];
        ALU_OR: return a | b;
        default: return a & b;
    endcase
endfunction

// rv32i funct3 for each alu operation
function automatic logic [2:0] funct3_of(input alu_op_t op);
    case (op)
        ALU_ADD, ALU_SUB: return 3'b000;
        ALU_SLL: return 3'b001;
        ALU_SLT: return 3'b010;
        ALU_SLTU: return 3'b011;
        ALU_XOR: return 3'b100;
        ALU_SRL, ALU_SRA: return 3'b101;
        ALU_OR: return 3'b110;
        default: return 3'b111;
    endcase
endfunction

function automatic logic [31:0] enc_r(input alu_op_t op, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] funct7;
    // sub and sra set funct7 bit 5
    funct7 = (op == ALU_SUB || op == ALU_SRA) ? 7'h20 : 7'h00;
    return {funct7, rs2, rs1, funct3_of(op), rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input alu_op_t op, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [11:0] imm);
    logic [11:0] field;
    field = imm;
    // shifts keep a 5 bit amount, sra marker in the upper bits
    if (op == ALU_SLL || op == ALU_SRL) begin
        field = {7'h00, imm[4:0]};
    end else if (op == ALU_SRA) begin
        field = {7'h20, imm[4:0]};
    end
    return {field, rs1, funct3_of(op), rd, 7'h13};
endfunction

// lui and auipc
function automatic logic [31:0] enc_u(input logic [6:0] opcode, input logic [4:0] rd,
        input logic [19:0] imm);
    return {imm, rd, opcode};
endfunction

`endif

/* verification/tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int RANDOM_COUNT = 400;
    localparam int DEP_COUNT = 200;
    localparam int BP_COUNT = 200;
    localparam int TAIL_COUNT = 6;
    localparam int INSTR_TOTAL = 2 * REG_COUNT + RANDOM_COUNT + DEP_COUNT + BP_COUNT +
            2 * TAIL_COUNT + 2;
    localparam int WATCHDOG_CYCLES = 40 * INSTR_TOTAL + 500;

    // expected command fields in port order
    typedef struct packed {
        logic halt;
        logic [4:0] rd;
        logic [3:0] op;
        logic [31:0] a;
        logic [31:0] b;
    } command_t;

    typedef struct packed {
        logic [31:0] due;
        logic [4:0] addr;
        logic [31:0] value;
    } writeback_t;

    logic clk, reset, instr_valid, instr_ready, exec_valid, exec_ready, exec_halt;
    logic [31:0] instr_data, instr_pc, exec_a, exec_b, wb_value, retired_count;
    logic [4:0] exec_rd, wb_addr;
    logic [7:0] exit_code;
    logic wb_valid, exit_flag, exited, held_valid;
    alu_op_t exec_op;

    command_t expect_q[$];
    writeback_t wb_q[$];
    command_t held;
    logic [31:0] pc;
    int ready_pct, wb_max_delay, cycle, transfers, halts, sent, retire_want;
    int check_count, error_count, test_start, stall;

    `include "tb_decode_model.svh"

    decode_stage UUT (
        .clk(clk), .reset(reset),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr_data(instr_data), .instr_pc(instr_pc),
        .exec_valid(exec_valid), .exec_ready(exec_ready), .exec_op(exec_op),
        .exec_a(exec_a), .exec_b(exec_b), .exec_rd(exec_rd), .exec_halt(exec_halt),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_value(wb_value),
        .exit_flag(exit_flag), .exit_code(exit_code), .retired_count(retired_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
        end
    endtask

    // execute unit with random ready, command checks and delayed writebacks
    always begin
        command_t seen, want;
        writeback_t wb;
        @(negedge clk);
        seen = {exec_halt, exec_rd, exec_op, exec_a, exec_b};
        // a stalled command keeps every field
        if (held_valid) begin
            check_value("exec_valid (stalled)", 32'(exec_valid), 32'd1);
            check_value("exec_a (stalled)", seen.a, held.a);
            check_value("exec_b (stalled)", seen.b, held.b);
            check_value("exec_op/rd/halt (stalled)", 32'({seen.op, seen.rd, seen.halt}),
                    32'({held.op, held.rd, held.halt}));
        end
        held_valid = exec_valid && !exec_ready;
        held = seen;
        if (exec_valid && exec_ready) begin
            transfers++;
            if (exec_halt) begin
                halts++;
            end
            if (expect_q.size() == 0) begin
                error_count++;
                $display("execute port sent a command that no instruction asked for");
            end else begin
                want = expect_q.pop_front();
                check_value("exec_halt", 32'(exec_halt), 32'(want.halt));
                check_value("exec_rd", 32'(exec_rd), 32'(want.rd));
                if (!want.halt) begin
                    check_value("exec_op", 32'(exec_op), 32'(want.op));
                    check_value("exec_a", exec_a, want.a);
                    check_value("exec_b", exec_b, want.b);
                end
            end
            if (exec_rd != '0) begin
                wb.due = cycle + 1 + $urandom_range(wb_max_delay, 1);
                wb.addr = exec_rd;
                wb.value = model_alu(exec_op, exec_a, exec_b);
                wb_q.push_back(wb);
            end
        end
        @(posedge clk);
        #1;
        exec_ready = ($urandom_range(99, 0) < ready_pct);
        if (wb_q.size() > 0 && wb_q[0].due <= cycle) begin
            wb = wb_q.pop_front();
            wb_valid = 1'b1;
            wb_addr = wb.addr;
            wb_value = wb.value;
        end else begin
            wb_valid = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // starts at a rising edge and returns at the accepting edge
    task automatic send_instr(input logic [31:0] word);
        logic ready_seen;
        #1;
        instr_valid = 1'b1;
        instr_data = word;
        instr_pc = pc;
        do begin
            @(negedge clk);
            ready_seen = instr_ready;
            @(posedge clk);
        end while (!ready_seen);
        pc = pc + 32'd4;
    endtask

    task automatic run_instr(input logic [31:0] word, input command_t cmd);
        logic [31:0] result;
        // dropped after a halt, so no command and no model change
        if (!exited) begin
            expect_q.push_back(cmd);
            result = model_alu(alu_op_t'(cmd.op), cmd.a, cmd.b);
            if (!cmd.halt && cmd.rd != '0) begin
                model_regs[cmd.rd] = result;
            end
            sent++;
            if (!cmd.halt) begin
                retire_want++;
            end
        end
        send_instr(word);
        if (cmd.halt) begin
            exited = 1'b1;
        end
    endtask

    task automatic issue_random(input int span);
        alu_op_t op;
        logic [4:0] rd, rs1, rs2;
        logic [19:0] upper;
        logic [11:0] field;
        logic [31:0] word, a, b;
        op = alu_op_t'(4'($urandom_range(9, 0)));
        rd = 5'($urandom_range(span - 1, 0));
        rs1 = 5'($urandom_range(span - 1, 0));
        rs2 = 5'($urandom_range(span - 1, 0));
        upper = 20'($urandom);
        case ($urandom_range(3, 0))
            0: begin
                word = enc_r(op, rd, rs1, rs2);
                a = model_regs[rs1];
                b = model_regs[rs2];
            end
            1: begin
                // no immediate subtract in rv32i
                if (op == ALU_SUB) begin
                    op = ALU_ADD;
                end
                // shift immediates hold a 5 bit amount and the sra marker
                field = upper[11:0];
                if (op == ALU_SLL || op == ALU_SRL) begin
                    field = {7'h00, upper[4:0]};
                end else if (op == ALU_SRA) begin
                    field = {7'h20, upper[4:0]};
                end
                word = enc_i(op, rd, rs1, field);
                a = model_regs[rs1];
                b = {{20{field[11]}}, field};
            end
            2: begin
                op = ALU_ADD;
                word = enc_u(7'h37, rd, upper);
                a = '0;
                b = {upper, 12'b0};
            end
            default: begin
                op = ALU_ADD;
                word = enc_u(7'h17, rd, upper);
                a = pc;
                b = {upper, 12'b0};
            end
        endcase
        run_instr(word, {1'b0, rd, op, a, b});
    endtask

    // every register must read zero after the clear
    task automatic read_cleared_regs();
        for (int r = 0; r < REG_COUNT; r++) begin
            run_instr(enc_r(ALU_ADD, 5'(r), 5'(r), 5'(r)), {1'b0, 5'(r), ALU_ADD, 64'd0});
        end
    endtask

    // stop feeding and wait until nothing is left in flight
    task automatic drain();
        #1;
        instr_valid = 1'b0;
        do begin
            @(negedge clk);
        end while (expect_q.size() != 0 || wb_q.size() != 0 || wb_valid || exec_valid);
        @(posedge clk);
        check_value("transfers", transfers, sent);
        check_value("retired_count", retired_count, retire_want);
    endtask

    task automatic apply_reset();
        #1;
        reset = 1'b1;
        instr_valid = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        pc = 32'h0000_1000;
        exited = 1'b0;
        retire_want = 0;
        // count stalled cycles while the register file clears
        stall = 0;
        do begin
            @(negedge clk);
            if (!instr_ready) begin
                stall++;
            end
        end while (!instr_ready);
        check_value("clear cycles", stall, REG_COUNT);
        check_value("exit_flag", 32'(exit_flag), 32'd0);
        check_value("exit_code", 32'(exit_code), 32'd0);
        check_value("retired_count", retired_count, 32'd0);
        @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_start) begin
            $display("test %-14s passed", name);
        end else begin
            $display("test %-14s failed with %0d errors", name, error_count - test_start);
        end
        test_start = error_count;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr_data = '0;
        instr_pc = '0;
        exec_ready = 1'b0;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_value = '0;
        {transfers, halts, sent, check_count, error_count, test_start} = '0;
        held_valid = 1'b0;
        ready_pct = 70;
        wb_max_delay = 6;
        void'($urandom(32'h0675_9c02));

        apply_reset();
        read_cleared_regs();
        drain();
        finish_test("reset clear");

        repeat (RANDOM_COUNT) issue_random(32);
        drain();
        finish_test("decode");

        // few registers, slow writebacks, many raw and waw stalls
        wb_max_delay = 24;
        ready_pct = 80;
        repeat (DEP_COUNT) issue_random(6);
        drain();
        finish_test("dependencies");

        wb_max_delay = 6;
        ready_pct = 25;
        repeat (BP_COUNT) issue_random(8);
        drain();
        finish_test("back-pressure");

        ready_pct = 70;
        run_instr(32'h0010_0073, {1'b1, 5'd0, ALU_ADD, 64'd0});
        @(negedge clk);
        check_value("exit_flag", 32'(exit_flag), 32'd1);
        check_value("exit_code", 32'(exit_code), 32'(model_regs[10][7:0]));
        @(posedge clk);
        repeat (TAIL_COUNT) issue_random(32);
        drain();
        check_value("halt commands", halts, 32'd1);
        finish_test("ebreak");

        // registers still hold values from the first run here
        apply_reset();
        read_cleared_regs();
        repeat (TAIL_COUNT) issue_random(32);
        // sw x5, 4(x2) is outside the kept opcodes
        run_instr({7'h00, 5'd5, 5'd2, 3'b010, 5'd4, 7'h23}, {1'b1, 5'd0, ALU_ADD, 64'd0});
        @(negedge clk);
        check_value("exit_flag", 32'(exit_flag), 32'd1);
        check_value("exit_code", 32'(exit_code), 32'd1);
        @(posedge clk);
        drain();
        check_value("halt commands", halts, 32'd2);
        finish_test("illegal");

        $display("summary: %0d checks, %0d errors, %0d commands transferred",
                check_count, error_count, transfers);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verification
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/reg_scoreboard.sv
hw/issue_controller.sv
hw/decode_stage.sv
verification/tb_decode_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f all.f --top-module tb_decode_stage -o sim_decode_stage

# the log decides the result, not the simulator exit status
./obj_dir/sim_decode_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
